// File: src/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // --------------------
    // Word and address widths
    localparam int unsigned NB_INST = 32;
    localparam int unsigned NB_ADDR = 32;

    // One instruction word
    typedef logic [NB_INST-1:0] inst_t;

    // One byte address, PC included
    typedef logic [NB_ADDR-1:0] addr_t;

    // --------------------
    // Redirect source for the next PC
    typedef enum logic [1:0] {
        PC_SRC_REG    = 2'b00,
        PC_SRC_BRANCH = 2'b01,
        PC_SRC_JUMP   = 2'b10
    } pc_src_e;

    // Byte distance between two instructions
    localparam addr_t PC_STEP = 32'd4;

endpackage

`default_nettype wire

// File: src/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // --------------------
    // Wishbone word address
    localparam int unsigned NB_WB_ADDR = 16;

    typedef logic [NB_WB_ADDR-1:0] wb_addr_t;

    // --------------------
    // Masters sharing the memory port
    typedef enum logic {
        MST_LOADER = 1'b0,
        MST_FETCH  = 1'b1
    } master_e;

endpackage

`default_nettype wire

// File: src/wb_if.sv
`timescale 1ns/10ps
`default_nettype none

interface wb_if;

    // Request side
    logic              cyc;
    logic              stb;
    logic              we;
    bus_pkg::wb_addr_t adr;
    isa_pkg::inst_t    dat_w;

    // Response side
    isa_pkg::inst_t    dat_r;
    logic              ack;

    modport master (
        output cyc,
        output stb,
        output we,
        output adr,
        output dat_w,
        input  dat_r,
        input  ack
    );

    // Mirror of the master view
    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  adr,
        input  dat_w,
        output dat_r,
        output ack
    );

endinterface

`default_nettype wire

// File: src/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit #(
    parameter int unsigned MEM_WORDS = 256
) (
    input  wire logic             i_clk,
    input  wire logic             i_rst_n,
    input  wire logic             i_debug_mode,
    input  wire logic             i_stall,
    input  wire logic             i_jump_or_branch,
    input  wire isa_pkg::pc_src_e i_pc_src,
    input  wire isa_pkg::addr_t   i_addr_register,
    input  wire isa_pkg::addr_t   i_addr_branch,
    input  wire isa_pkg::addr_t   i_addr_jump,
    output isa_pkg::inst_t        o_instruction,
    output isa_pkg::addr_t        o_pc,
    output isa_pkg::addr_t        o_next_pc,
    output logic                  o_inst_valid,
    wb_if.master                  bus
);

    localparam int unsigned NB_IDX = $clog2(MEM_WORDS);

    isa_pkg::addr_t pc_q;
    isa_pkg::addr_t seq_pc;
    isa_pkg::addr_t redirect_pc;
    isa_pkg::addr_t next_pc;
    isa_pkg::inst_t inst_q;
    logic           inst_valid_q;
    logic           rd_busy_q;
    logic           rd_done;
    logic           take;
    logic           start_rd;

    // --------------------
    // Next PC selection
    assign seq_pc = pc_q + isa_pkg::PC_STEP;

    // Code 11 is unused and falls back to the register target
    always_comb begin
        case (i_pc_src)
            isa_pkg::PC_SRC_BRANCH: redirect_pc = i_addr_branch;
            isa_pkg::PC_SRC_JUMP:   redirect_pc = i_addr_jump;
            default:                redirect_pc = i_addr_register;
        endcase
    end

    assign next_pc = i_jump_or_branch ? redirect_pc : seq_pc;

    // --------------------
    // Handshake with the decode side
    assign take    = inst_valid_q && !i_stall;
    assign rd_done = rd_busy_q && bus.ack;

    // Read when idle and empty, or in the same edge the held word leaves
    assign start_rd = !i_debug_mode && !rd_busy_q && (take || !inst_valid_q);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc_q         <= '0;
            inst_valid_q <= 1'b0;
            rd_busy_q    <= 1'b0;
        end else begin
            if (take) begin
                pc_q         <= next_pc;
                inst_valid_q <= 1'b0;
            end
            if (start_rd) begin
                rd_busy_q <= 1'b1;
            end
            // A read never completes while a word is held
            if (rd_done) begin
                rd_busy_q    <= 1'b0;
                inst_valid_q <= 1'b1;
            end
        end
    end

    // Captured word, held through stalls
    always_ff @(posedge i_clk) begin
        if (rd_done) begin
            inst_q <= bus.dat_r;
        end
    end

    // --------------------
    // Wishbone read master
    assign bus.cyc   = rd_busy_q;
    assign bus.stb   = rd_busy_q;
    assign bus.we    = 1'b0;
    assign bus.dat_w = '0;

    // Byte PC to word index, folded to the memory depth
    assign bus.adr = bus_pkg::wb_addr_t'(pc_q[NB_IDX+1:2]);

    assign o_instruction = inst_q;
    assign o_pc          = pc_q;
    assign o_next_pc     = seq_pc;
    assign o_inst_valid  = inst_valid_q;

endmodule

`default_nettype wire

// File: src/debug_loader.sv
`timescale 1ns/10ps
`default_nettype none

module debug_loader #(
    parameter int unsigned MEM_WORDS = 256
) (
    input  wire logic           i_clk,
    input  wire logic           i_rst_n,
    input  wire logic           i_load_valid,
    input  wire isa_pkg::addr_t i_load_addr,
    input  wire isa_pkg::inst_t i_load_data,
    output logic                o_load_ready,
    wb_if.master                bus
);

    localparam int unsigned NB_IDX = $clog2(MEM_WORDS);

    logic              ready_q;
    logic              accept;
    bus_pkg::wb_addr_t adr_q;
    isa_pkg::inst_t    dat_q;

    // --------------------
    // Load port side
    assign accept = i_load_valid && ready_q;

    // Ready stays low for the whole write
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ready_q <= 1'b1;
        end else if (accept) begin
            ready_q <= 1'b0;
        end else if (!ready_q && bus.ack) begin
            ready_q <= 1'b1;
        end
    end

    // Pair captured on acceptance, same folding as fetch
    always_ff @(posedge i_clk) begin
        if (accept) begin
            adr_q <= bus_pkg::wb_addr_t'(i_load_addr[NB_IDX+1:2]);
            dat_q <= i_load_data;
        end
    end

    // --------------------
    // Wishbone write master
    assign bus.cyc   = !ready_q;
    assign bus.stb   = !ready_q;
    assign bus.we    = !ready_q;
    assign bus.adr   = adr_q;
    assign bus.dat_w = dat_q;

    assign o_load_ready = ready_q;

endmodule

`default_nettype wire

// File: src/imem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module imem_arbiter (
    input wire logic i_clk,
    input wire logic i_rst_n,
    wb_if.slave      fetch_bus,
    wb_if.slave      load_bus,
    wb_if.master     mem_bus
);

    bus_pkg::master_e owner_q;
    bus_pkg::master_e grant;
    logic             busy_q;
    logic             to_loader;

    // --------------------
    // Grant selection
    // Loader first when no cycle is owned
    always_comb begin
        if (busy_q) begin
            grant = owner_q;
        end else if (load_bus.cyc) begin
            grant = bus_pkg::MST_LOADER;
        end else begin
            grant = bus_pkg::MST_FETCH;
        end
    end

    assign to_loader = (grant == bus_pkg::MST_LOADER);

    // Owner latched on the first request cycle, dropped on ack
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            busy_q  <= 1'b0;
            owner_q <= bus_pkg::MST_FETCH;
        end else if (busy_q) begin
            if (!mem_bus.cyc || mem_bus.ack) begin
                busy_q <= 1'b0;
            end
        end else if (mem_bus.cyc && mem_bus.stb) begin
            busy_q  <= 1'b1;
            owner_q <= grant;
        end
    end

    // --------------------
    // Request path to memory
    assign mem_bus.cyc   = to_loader ? load_bus.cyc   : fetch_bus.cyc;
    assign mem_bus.stb   = to_loader ? load_bus.stb   : fetch_bus.stb;
    assign mem_bus.we    = to_loader ? load_bus.we    : fetch_bus.we;
    assign mem_bus.adr   = to_loader ? load_bus.adr   : fetch_bus.adr;
    assign mem_bus.dat_w = to_loader ? load_bus.dat_w : fetch_bus.dat_w;

    // Response goes back to the owner only
    assign load_bus.ack    = to_loader && mem_bus.ack;
    assign fetch_bus.ack   = !to_loader && mem_bus.ack;
    assign load_bus.dat_r  = to_loader ? mem_bus.dat_r : '0;
    assign fetch_bus.dat_r = to_loader ? '0 : mem_bus.dat_r;

endmodule

`default_nettype wire

// File: src/inst_mem.sv
`timescale 1ns/10ps
`default_nettype none

module inst_mem #(
    parameter int unsigned MEM_WORDS = 256
) (
    input wire logic i_clk,
    input wire logic i_rst_n,
    wb_if.slave      bus
);

    localparam int unsigned NB_IDX = $clog2(MEM_WORDS);

    isa_pkg::inst_t    mem [MEM_WORDS];
    isa_pkg::inst_t    rd_data_q;
    logic              ack_q;
    logic              req;
    logic [NB_IDX-1:0] idx;

    // Ignore the request in its own ack cycle
    assign req = bus.cyc && bus.stb && !ack_q;
    assign idx = bus.adr[NB_IDX-1:0];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    // Contents stay undefined until loaded
    always_ff @(posedge i_clk) begin
        if (req) begin
            if (bus.we) begin
                mem[idx] <= bus.dat_w;
            end
            rd_data_q <= mem[idx];
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = rd_data_q;

endmodule

`default_nettype wire

// File: src/fetch_top.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_top #(
    parameter int unsigned MEM_WORDS = 256
) (
    input  wire logic             i_clk,
    input  wire logic             i_rst_n,
    input  wire logic             i_debug_mode,
    input  wire logic             i_stall,
    input  wire logic             i_jump_or_branch,
    input  wire isa_pkg::pc_src_e i_pc_src,
    input  wire isa_pkg::addr_t   i_addr_register,
    input  wire isa_pkg::addr_t   i_addr_branch,
    input  wire isa_pkg::addr_t   i_addr_jump,
    input  wire logic             i_load_valid,
    input  wire isa_pkg::addr_t   i_load_addr,
    input  wire isa_pkg::inst_t   i_load_data,
    output wire isa_pkg::inst_t   o_instruction,
    output wire isa_pkg::addr_t   o_pc,
    output wire isa_pkg::addr_t   o_next_pc,
    output wire logic             o_inst_valid,
    output wire logic             o_load_ready
);

    // --------------------
    // Bus segments
    wb_if wb_fetch ();
    wb_if wb_load ();
    wb_if wb_mem ();

    fetch_unit #(.MEM_WORDS(MEM_WORDS)) u_fetch_unit (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_debug_mode     (i_debug_mode),
        .i_stall          (i_stall),
        .i_jump_or_branch (i_jump_or_branch),
        .i_pc_src         (i_pc_src),
        .i_addr_register  (i_addr_register),
        .i_addr_branch    (i_addr_branch),
        .i_addr_jump      (i_addr_jump),
        .o_instruction    (o_instruction),
        .o_pc             (o_pc),
        .o_next_pc        (o_next_pc),
        .o_inst_valid     (o_inst_valid),
        .bus              (wb_fetch)
    );

    // Loads are taken in any mode
    debug_loader #(.MEM_WORDS(MEM_WORDS)) u_debug_loader (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_load_valid (i_load_valid),
        .i_load_addr  (i_load_addr),
        .i_load_data  (i_load_data),
        .o_load_ready (o_load_ready),
        .bus          (wb_load)
    );

    imem_arbiter u_imem_arbiter (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .fetch_bus (wb_fetch),
        .load_bus  (wb_load),
        .mem_bus   (wb_mem)
    );

    inst_mem #(.MEM_WORDS(MEM_WORDS)) u_inst_mem (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .bus     (wb_mem)
    );

endmodule

`default_nettype wire

// File: bench/tb_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module tb_fetch;

    localparam int unsigned MEM_WORDS = 256;
    localparam int unsigned MAX_CYCLES = 4000;

    logic             i_clk;
    logic             i_rst_n;
    logic             i_debug_mode;
    logic             i_stall;
    logic             i_jump_or_branch;
    isa_pkg::pc_src_e i_pc_src;
    isa_pkg::addr_t   i_addr_register;
    isa_pkg::addr_t   i_addr_branch;
    isa_pkg::addr_t   i_addr_jump;
    logic             i_load_valid;
    isa_pkg::addr_t   i_load_addr;
    isa_pkg::inst_t   i_load_data;
    isa_pkg::inst_t   o_instruction;
    isa_pkg::addr_t   o_pc;
    isa_pkg::addr_t   o_next_pc;
    logic             o_inst_valid;
    logic             o_load_ready;

    // Shadow of the memory, with a flag per loaded word
    isa_pkg::inst_t shadow [MEM_WORDS];
    logic           known [MEM_WORDS];

    isa_pkg::addr_t model_pc;
    isa_pkg::addr_t last_pc;
    isa_pkg::addr_t held_pc;
    isa_pkg::inst_t held_inst;
    logic           held;
    int             take_count;
    int             err_count;
    int             cycle_count;
    int             tests_ok;
    int             tests_bad;

    fetch_top #(.MEM_WORDS(MEM_WORDS)) i_fetch_top (.*);

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    // --------------------
    // Reference model
    function automatic void ref_fetch(input isa_pkg::addr_t pc, input logic jb,
                                      input isa_pkg::pc_src_e src,
                                      input isa_pkg::addr_t a_reg, input isa_pkg::addr_t a_br,
                                      input isa_pkg::addr_t a_jmp,
                                      output isa_pkg::addr_t exp_next,
                                      output isa_pkg::inst_t exp_inst,
                                      output logic exp_known);
        int word;
        word = int'((pc >> 2) % MEM_WORDS);
        exp_inst = shadow[word];
        exp_known = known[word];
        if (!jb) begin
            exp_next = pc + 32'd4;
        end else if (src == isa_pkg::PC_SRC_BRANCH) begin
            exp_next = a_br;
        end else if (src == isa_pkg::PC_SRC_JUMP) begin
            exp_next = a_jmp;
        end else begin
            exp_next = a_reg;
        end
    endfunction

    // --------------------
    // Compare tasks
    task automatic check_inst(input string name, input isa_pkg::inst_t exp,
                              input isa_pkg::inst_t act);
        if (act !== exp) begin
            err_count++;
            $display("FAILED %s expected %08h actual %08h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input isa_pkg::addr_t exp,
                              input isa_pkg::addr_t act);
        if (act !== exp) begin
            err_count++;
            $display("FAILED %s expected %08h actual %08h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_count++;
            $display("FAILED %s expected %b actual %b", name, exp, act);
        end
    endtask

    // Outputs sampled on the falling edge, away from input changes
    always @(negedge i_clk) begin
        isa_pkg::addr_t nxt;
        isa_pkg::inst_t exp_inst;
        logic           exp_known;
        if (i_rst_n && o_inst_valid) begin
            if (held) begin
                check_addr("hold_pc", held_pc, o_pc);
                check_inst("hold_inst", held_inst, o_instruction);
            end else begin
                held = 1'b1;
                held_pc = o_pc;
                held_inst = o_instruction;
            end
            if (!i_stall) begin
                ref_fetch(model_pc, i_jump_or_branch, i_pc_src, i_addr_register,
                          i_addr_branch, i_addr_jump, nxt, exp_inst, exp_known);
                check_addr("take_pc", model_pc, o_pc);
                check_addr("next_pc", model_pc + 32'd4, o_next_pc);
                if (exp_known) begin
                    check_inst("take_inst", exp_inst, o_instruction);
                end
                last_pc = o_pc;
                model_pc = nxt;
                held = 1'b0;
                take_count++;
            end
        end
    end

    always @(posedge i_clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // --------------------
    // Stimulus helpers
    task automatic next_cycle();
        @(posedge i_clk);
        #2;
    endtask

    task automatic load_word(input int word, input isa_pkg::inst_t data);
        i_load_valid = 1'b1;
        i_load_addr = isa_pkg::addr_t'(word) << 2;
        i_load_data = data;
        @(negedge i_clk);
        while (!o_load_ready) begin
            @(negedge i_clk);
        end
        shadow[word] = data;
        known[word] = 1'b1;
        next_cycle();
        i_load_valid = 1'b0;
        check_flag("load_busy", 1'b0, o_load_ready);
        while (!o_load_ready) begin
            next_cycle();
        end
    endtask

    task automatic wait_takes(input int n);
        int target;
        target = take_count + n;
        while (take_count < target) begin
            next_cycle();
        end
    endtask

    task automatic report(input string name, input int errs_before);
        if (err_count == errs_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d mismatches", name, err_count - errs_before);
        end
    endtask

    initial begin
        isa_pkg::pc_src_e srcs [3];
        isa_pkg::addr_t   target;
        int               errs;
        int               start_takes;
        int               base;
        void'($urandom(32'h6e7b));
        srcs[0] = isa_pkg::PC_SRC_REG;
        srcs[1] = isa_pkg::PC_SRC_BRANCH;
        srcs[2] = isa_pkg::PC_SRC_JUMP;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = '0;
            known[i] = 1'b0;
        end
        model_pc = '0;
        last_pc = '0;
        held = 1'b0;
        take_count = 0;
        err_count = 0;
        cycle_count = 0;
        tests_ok = 0;
        tests_bad = 0;
        i_rst_n = 1'b0;
        i_debug_mode = 1'b1;
        i_stall = 1'b0;
        i_jump_or_branch = 1'b0;
        i_pc_src = isa_pkg::PC_SRC_REG;
        i_addr_register = '0;
        i_addr_branch = '0;
        i_addr_jump = '0;
        i_load_valid = 1'b0;
        i_load_addr = '0;
        i_load_data = '0;
        repeat (4) next_cycle();
        i_rst_n = 1'b1;

        // --------------------
        errs = err_count;
        next_cycle();
        check_flag("reset_valid", 1'b0, o_inst_valid);
        check_flag("reset_ready", 1'b1, o_load_ready);
        report("reset_state", errs);

        errs = err_count;
        for (int i = 0; i < 64; i++) begin
            load_word(i, $urandom);
            check_flag("debug_halt", 1'b0, o_inst_valid);
        end
        report("debug_load", errs);

        // First take is at PC 0 by the model
        errs = err_count;
        i_debug_mode = 1'b0;
        wait_takes(64);
        report("sequential", errs);

        // --------------------
        errs = err_count;
        for (int k = 0; k < 3; k++) begin
            target = isa_pkg::addr_t'($urandom % 64) << 2;
            i_pc_src = srcs[k];
            i_addr_register = target;
            i_addr_branch = target;
            i_addr_jump = target;
            if (k != 0) i_addr_register = target + 32'd64;
            if (k != 1) i_addr_branch = target + 32'd128;
            if (k != 2) i_addr_jump = target + 32'd192;
            i_jump_or_branch = 1'b1;
            wait_takes(1);
            i_jump_or_branch = 1'b0;
            wait_takes(1);
            check_addr("redirect_target", target, last_pc);
            wait_takes(3);
        end
        report("redirect", errs);

        errs = err_count;
        for (int n = 0; n < 40; n++) begin
            start_takes = take_count;
            while (take_count == start_takes) begin
                i_stall = 1'($urandom % 2);
                next_cycle();
            end
        end
        i_stall = 1'b0;
        report("back_pressure", errs);

        // --------------------
        errs = err_count;
        start_takes = take_count;
        base = int'((model_pc >> 2) % MEM_WORDS) + 24;
        for (int i = 0; i < 8; i++) begin
            load_word((base + i) % MEM_WORDS, $urandom);
        end
        check_flag("fetch_progress", 1'b1, take_count > start_takes);
        while (take_count < start_takes + 40) begin
            next_cycle();
        end
        report("load_during_run", errs);

        $display("tests passed %0d, tests failed %0d, mismatches %0d",
                 tests_ok, tests_bad, err_count);
        if (tests_bad == 0 && err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
src/isa_pkg.sv
src/bus_pkg.sv
src/wb_if.sv
src/fetch_unit.sv
src/debug_loader.sv
src/imem_arbiter.sv
src/inst_mem.sv
src/fetch_top.sv
bench/tb_fetch.sv

// File: Makefile
# Verilator build and run for the fetch stage testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch
BUILD_DIR ?= obj_dir
FILELIST  ?= sim.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(wildcard src/*.sv) $(wildcard bench/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -qx "Test passed" $(LOG); then \
		echo "Simulation log shows a pass"; \
	else \
		echo "Simulation log shows no pass"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
